// File: spc700Pkg.sv
package spc700Pkg;

    // Secondary opcode seen by the arithmetic block.
    typedef enum logic [3:0] {
        OP_INIT = 4'b0000, // Operand load.
        OP_MUL  = 4'b1110, // One shift-add step.
        OP_DIV  = 4'b1111  // One compare-subtract step.
    } secOpE;

    // Requested instruction, MUL YA or DIV YA,X.
    typedef enum logic {
        MD_MUL = 1'b0,
        MD_DIV = 1'b1
    } mulDivOpE;

    // Control word for the arithmetic block.
    typedef struct packed {
        secOpE secOp;
    } SpcALUCtrl_r;

    // Status bits touched by MUL and DIV.
    typedef struct packed {
        logic n;
        logic v;
        logic h;
        logic z;
    } spcFlags_t;

    // Register select codes for external loads.
    localparam logic [1:0] REG_SEL_A = 2'd0;
    localparam logic [1:0] REG_SEL_X = 2'd1;
    localparam logic [1:0] REG_SEL_Y = 2'd2;

    // External register write.
    typedef struct packed {
        logic       en;
        logic [1:0] sel;  // One of the REG_SEL codes.
        logic [7:0] data;
    } regLoad_t;

    // Arithmetic step counts, fixed by the instruction set.
    localparam int MUL_STEPS = 8;
    localparam int DIV_STEPS = 9;

endpackage

// File: MulDiv.sv
`timescale 1ns/100ps

module MulDiv
    import spc700Pkg::*;
#(
    parameter int DATA_W = 8,
    parameter int RES_W  = 16
) (
    input  logic              CLK,
    input  logic              RST_N,
    input  logic              EN,
    input  SpcALUCtrl_r       CTRL,
    input  logic [DATA_W-1:0] A,
    input  logic [DATA_W-1:0] X,
    input  logic [DATA_W-1:0] Y,
    output logic [RES_W-1:0]  RES,
    output logic              ZO,
    output logic              VO,
    output logic              HO,
    output logic              SO
);

    logic [RES_W-1:0]  mulRes;    // Partial product.
    logic [RES_W-1:0]  mulA;      // Shifted multiplicand.
    logic [DATA_W-1:0] mulY;      // Multiplier, consumed LSB first.
    logic [RES_W-1:0]  divt;      // Shifted divisor.
    logic [RES_W-1:0]  remainder;
    logic [DATA_W-1:0] quotient;  // Quotient bits so far, low 8 only.

    logic [RES_W-1:0]  mulSum;
    logic              divGe;
    logic [RES_W-1:0]  remNext;
    logic [DATA_W:0]   quoNext;   // 9 quotient bits.

    // Next step values, also the visible result of the current step.
    always_comb begin
        mulSum  = mulY[0] ? (mulRes + mulA) : mulRes;
        divGe   = (remainder >= divt);
        remNext = divGe ? (remainder - divt) : remainder;
        quoNext = {quotient, divGe};
    end

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            mulRes    <= '0;
            mulA      <= '0;
            mulY      <= '0;
            divt      <= '0;
            remainder <= '0;
            quotient  <= '0;
        end else if (EN) begin
            case (CTRL.secOp)
                OP_MUL: begin
                    mulRes <= mulSum;
                    mulA   <= {mulA[RES_W-2:0], 1'b0};
                    mulY   <= {1'b0, mulY[DATA_W-1:1]};
                end
                OP_DIV: begin
                    remainder <= remNext;
                    quotient  <= quoNext[DATA_W-1:0];
                    divt      <= {1'b0, divt[RES_W-1:1]};
                end
                default: begin
                    mulRes    <= '0;
                    mulA      <= {{(RES_W-DATA_W){1'b0}}, A};
                    mulY      <= Y;
                    divt      <= {X, {DATA_W{1'b0}}}; // Divisor aligned to the high byte.
                    remainder <= {Y, A};
                    quotient  <= '0;
                end
            endcase
        end
    end

    always_comb begin
        RES = '0;
        ZO  = 1'b0;
        VO  = 1'b0;
        SO  = 1'b0;
        case (CTRL.secOp)
            OP_MUL: begin
                RES = mulSum;
                ZO  = (mulSum[RES_W-1:DATA_W] == '0); // Z from Y only.
                SO  = mulSum[RES_W-1];
            end
            OP_DIV: begin
                RES = {remNext[DATA_W-1:0], quoNext[DATA_W-1:0]}; // Remainder in Y, quotient in A.
                ZO  = (quoNext[DATA_W-1:0] == '0);
                VO  = quoNext[DATA_W];
                SO  = quoNext[DATA_W-1];
            end
            default: ;
        endcase
    end

    // Half-carry test on the original operands; Y is untouched until writeback.
    assign HO = (Y[3:0] >= X[3:0]);

endmodule

// File: MulDivSeq.sv
`timescale 1ns/100ps

module MulDivSeq
    import spc700Pkg::*;
(
    input  logic        CLK,
    input  logic        RST_N,
    input  logic        start,
    input  mulDivOpE    op,
    output logic        EN,
    output SpcALUCtrl_r CTRL,
    output logic        wbEn,
    output logic        busy,
    output logic        done
);

    typedef enum logic [1:0] {
        IDLE,
        INIT,
        STEP,
        DONE
    } seqStateE;

    seqStateE   state;
    mulDivOpE   opQ;      // Instruction latched at start.
    logic [3:0] stepCnt;
    logic [3:0] lastCnt;
    logic       lastStep;

    assign lastCnt  = (opQ == MD_DIV) ? 4'(DIV_STEPS - 1) : 4'(MUL_STEPS - 1);
    assign lastStep = (stepCnt == lastCnt);

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            state   <= IDLE;
            opQ     <= MD_MUL;
            stepCnt <= '0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (start) begin
                        state <= INIT;
                        opQ   <= op;
                    end else begin
                        state <= IDLE;
                    end
                end
                INIT: begin
                    state   <= STEP;
                    stepCnt <= '0;
                end
                STEP: begin
                    stepCnt <= stepCnt + 4'd1;
                    if (lastStep) begin
                        state <= DONE; // Writeback happens on this edge.
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_comb begin
        CTRL.secOp = OP_INIT;
        if (state == STEP) begin
            CTRL.secOp = (opQ == MD_DIV) ? OP_DIV : OP_MUL;
        end
    end

    assign EN   = (state == INIT) || (state == STEP);
    assign wbEn = (state == STEP) && lastStep;
    assign busy = EN;
    assign done = (state == DONE); // One cycle, straight from the state register.

endmodule

// File: SpcRegFile.sv
`timescale 1ns/100ps

module SpcRegFile
    import spc700Pkg::*;
#(
    parameter int DATA_W = 8,
    parameter int RES_W  = 16
) (
    input  logic              CLK,
    input  logic              RST_N,
    input  regLoad_t          load,
    input  logic              busy,
    input  logic              wbEn,
    input  logic              isDiv,
    input  logic [RES_W-1:0]  res,
    input  logic              zIn,
    input  logic              vIn,
    input  logic              hIn,
    input  logic              nIn,
    output logic [DATA_W-1:0] regA,
    output logic [DATA_W-1:0] regX,
    output logic [DATA_W-1:0] regY,
    output spcFlags_t         flags
);

    logic loadOk;

    assign loadOk = load.en && !busy; // Loads are dropped during an operation.

    always_ff @(posedge CLK) begin
        if (!RST_N) begin
            regA  <= '0;
            regX  <= '0;
            regY  <= '0;
            flags <= '0;
        end else if (wbEn) begin
            regA    <= res[DATA_W-1:0];
            regY    <= res[RES_W-1:DATA_W];
            flags.n <= nIn;
            flags.z <= zIn;
            // MUL clears V and leaves H alone.
            flags.v <= isDiv ? vIn : 1'b0;
            flags.h <= isDiv ? hIn : flags.h;
        end else if (loadOk) begin
            case (load.sel)
                REG_SEL_A: regA <= load.data;
                REG_SEL_X: regX <= load.data;
                REG_SEL_Y: regY <= load.data;
                default: ; // Unused select code.
            endcase
        end
    end

endmodule

// File: SpcMulDivTop.sv
`timescale 1ns/100ps

module SpcMulDivTop
    import spc700Pkg::*;
#(
    parameter int DATA_W = 8,
    parameter int RES_W  = 16
) (
    input  logic              CLK,
    input  logic              RST_N,
    input  logic              start,
    input  mulDivOpE          op,
    input  regLoad_t          load,
    output logic              busy,
    output logic              done,
    output logic [DATA_W-1:0] regA,
    output logic [DATA_W-1:0] regX,
    output logic [DATA_W-1:0] regY,
    output spcFlags_t         flags
);

    logic             aluEn;
    SpcALUCtrl_r      aluCtrl;
    logic             wbEn;
    logic [RES_W-1:0] aluRes;
    logic             aluZ;
    logic             aluV;
    logic             aluH;
    logic             aluN;
    logic             isDiv;

    assign isDiv = (aluCtrl.secOp == OP_DIV); // Valid during the writeback step.

    MulDivSeq u_seq (
        .CLK   (CLK),
        .RST_N (RST_N),
        .start (start),
        .op    (op),
        .EN    (aluEn),
        .CTRL  (aluCtrl),
        .wbEn  (wbEn),
        .busy  (busy),
        .done  (done)
    );

    MulDiv #(
        .DATA_W (DATA_W),
        .RES_W  (RES_W)
    ) u_mulDiv (
        .CLK   (CLK),
        .RST_N (RST_N),
        .EN    (aluEn),
        .CTRL  (aluCtrl),
        .A     (regA),
        .X     (regX),
        .Y     (regY),
        .RES   (aluRes),
        .ZO    (aluZ),
        .VO    (aluV),
        .HO    (aluH),
        .SO    (aluN)
    );

    SpcRegFile #(
        .DATA_W (DATA_W),
        .RES_W  (RES_W)
    ) u_regFile (
        .CLK   (CLK),
        .RST_N (RST_N),
        .load  (load),
        .busy  (busy),
        .wbEn  (wbEn),
        .isDiv (isDiv),
        .res   (aluRes),
        .zIn   (aluZ),
        .vIn   (aluV),
        .hIn   (aluH),
        .nIn   (aluN),
        .regA  (regA),
        .regX  (regX),
        .regY  (regY),
        .flags (flags)
    );

endmodule

// File: SpcMulDivTb.sv
`timescale 1ns/100ps

module SpcMulDivTb
    import spc700Pkg::*;
();

    localparam int NUM_OPS         = 50;                       // 2 directed, 24 pairs.
    localparam int WATCHDOG_CYCLES = NUM_OPS * (14 + 3) + 100; // Plus 3 load cycles per op.

    logic      CLK;
    logic      RST_N;
    logic      start;
    mulDivOpE  op;
    regLoad_t  load;
    logic      busy;
    logic      done;
    logic [7:0] regA;
    logic [7:0] regX;
    logic [7:0] regY;
    spcFlags_t flags;

    logic [7:0] shA;     // Expected register contents.
    logic [7:0] shX;
    logic [7:0] shY;
    spcFlags_t  shFlags;
    int         errCnt;
    int         opCnt;

    SpcMulDivTop #(
        .DATA_W (8),
        .RES_W  (16)
    ) u_dut (
        .CLK   (CLK),
        .RST_N (RST_N),
        .start (start),
        .op    (op),
        .load  (load),
        .busy  (busy),
        .done  (done),
        .regA  (regA),
        .regX  (regX),
        .regY  (regY),
        .flags (flags)
    );

    initial CLK = 1'b0;
    always #2 CLK = ~CLK;

    task automatic reportMismatch(input string name, input logic [7:0] got, input logic [7:0] exp);
        errCnt++;
        $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    endtask

    task automatic reportFailure(input string what);
        errCnt++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic loadReg(input logic [1:0] sel, input logic [7:0] data);
        @(posedge CLK);
        load <= {1'b1, sel, data}; // Stays enabled until the next start.
        case (sel)
            REG_SEL_A: shA <= data;
            REG_SEL_X: shX <= data;
            default:   shY <= data;
        endcase
    endtask

    task automatic loadOperands(input logic [7:0] a, input logic [7:0] x, input logic [7:0] y);
        loadReg(REG_SEL_A, a);
        loadReg(REG_SEL_X, x);
        loadReg(REG_SEL_Y, y);
    endtask

    // Issues one operation; intrude adds a start and an X load while busy.
    task automatic startOp(input mulDivOpE o, input bit intrude);
        logic [15:0] prod;
        logic [15:0] quo;
        logic [15:0] rem;
        spcFlags_t   nf;
        @(posedge CLK);
        load  <= '0;
        start <= 1'b1;
        op    <= o;
        if (o == MD_MUL) begin
            prod = {8'h00, shY} * {8'h00, shA};
            nf.n = prod[15];
            nf.v = 1'b0;
            nf.h = shFlags.h;
            nf.z = (prod[15:8] == 8'h00);
            shA <= prod[7:0];
            shY <= prod[15:8];
        end else begin
            quo  = {shY, shA} / {8'h00, shX};
            rem  = {shY, shA} % {8'h00, shX};
            nf.n = quo[7];
            nf.v = quo[8];
            nf.h = (shY[3:0] >= shX[3:0]);
            nf.z = (quo[7:0] == 8'h00);
            shA <= quo[7:0];
            shY <= rem[7:0];
        end
        shFlags <= nf;
        opCnt++;
        @(posedge CLK);
        start <= 1'b0;
        if (intrude) begin
            @(posedge CLK);
            start <= 1'b1;
            op    <= (o == MD_MUL) ? MD_DIV : MD_MUL;
            load  <= {1'b1, REG_SEL_X, ~shX};
            @(posedge CLK);
            start <= 1'b0;
            load  <= '0;
        end
    endtask

    task automatic waitDone();
        do begin
            @(negedge CLK);
        end while (!done);
    endtask

    chkReset: assert property (@(posedge CLK) $rose(RST_N) |-> !busy && !done
            && regA == 8'h00 && regX == 8'h00 && regY == 8'h00 && flags == '0)
        else reportFailure("busy, done, registers or flags not cleared by reset");
    chkA: assert property (@(posedge CLK) disable iff (!RST_N) done |-> regA == shA)
        else reportMismatch("regA", $sampled(regA), $sampled(shA));
    chkX: assert property (@(posedge CLK) disable iff (!RST_N) done |-> regX == shX)
        else reportMismatch("regX", $sampled(regX), $sampled(shX));
    chkY: assert property (@(posedge CLK) disable iff (!RST_N) done |-> regY == shY)
        else reportMismatch("regY", $sampled(regY), $sampled(shY));
    chkFlags: assert property (@(posedge CLK) disable iff (!RST_N) done |-> flags == shFlags)
        else reportMismatch("flags", {4'h0, $sampled(flags)}, {4'h0, $sampled(shFlags)});
    chkMulLat: assert property (@(posedge CLK) disable iff (!RST_N)
            $past(start && !busy && op == MD_MUL, 10) |-> $rose(done))
        else reportFailure("done did not rise 9 cycles after an accepted MUL start");
    chkDivLat: assert property (@(posedge CLK) disable iff (!RST_N)
            $past(start && !busy && op == MD_DIV, 11) |-> $rose(done))
        else reportFailure("done did not rise 10 cycles after an accepted DIV start");
    chkDoneSrc: assert property (@(posedge CLK) disable iff (!RST_N) $rose(done) |->
            $past(start && !busy && op == MD_MUL, 10) || $past(start && !busy && op == MD_DIV, 11))
        else reportFailure("done rose without a matching accepted start");
    chkPulse: assert property (@(posedge CLK) disable iff (!RST_N) done |=> !done)
        else reportFailure("done stayed high for more than one cycle");
    chkIdle: assert property (@(posedge CLK) disable iff (!RST_N) done |-> !busy)
        else reportFailure("busy still high while done is high");
    chkBusy: assert property (@(posedge CLK) disable iff (!RST_N)
            !busy |=> busy == $past(start))
        else reportFailure("busy did not follow the start strobe while idle");
    chkHold: assert property (@(posedge CLK) disable iff (!RST_N) busy && $past(busy) |->
            $stable(regA) && $stable(regX) && $stable(regY))
        else reportFailure("a register changed before the writeback step");

    initial begin
        mulDivOpE o;
        int       x;
        int       lim;
        void'($urandom(80));
        RST_N   = 1'b0;
        start   = 1'b0;
        op      = MD_MUL;
        load    = '0;
        shA     = '0;
        shX     = '0;
        shY     = '0;
        shFlags = '0;
        errCnt  = 0;
        opCnt   = 0;
        repeat (5) @(posedge CLK);
        RST_N <= 1'b1;
        @(posedge CLK);
        loadOperands(8'hC5, 8'h3A, 8'hF7);
        startOp(MD_MUL, 1'b1);
        waitDone();
        loadOperands(8'h34, 8'h21, 8'h40); // Quotient above 255, sets V.
        startOp(MD_DIV, 1'b1);
        waitDone();
        for (int i = 0; i < (NUM_OPS - 2) / 2; i++) begin
            o   = ($urandom % 2 == 0) ? MD_MUL : MD_DIV;
            x   = 1 + int'($urandom % 255);
            lim = (o == MD_DIV && 2 * x < 256) ? 2 * x : 256;
            loadOperands(8'($urandom), 8'(x), 8'(int'($urandom % 256) % lim));
            startOp(o, 1'b0);
            waitDone();
            startOp(o, 1'b0); // Chained on the previous result.
            waitDone();
        end
        repeat (2) @(posedge CLK);
        $display("Summary: %0d operations, %0d errors", opCnt, errCnt);
        if (errCnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 4);
        $display("Timeout after %0d cycles with %0d operations, %0d errors",
                 WATCHDOG_CYCLES, opCnt, errCnt);
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: build.f
spc700Pkg.sv
MulDiv.sv
MulDivSeq.sv
SpcRegFile.sv
SpcMulDivTop.sv
SpcMulDivTb.sv

// File: Makefile
VERILATOR = verilator
TOP       = SpcMulDivTb
RTL_TOP   = SpcMulDivTop
FILELIST  = build.f
OBJ_DIR   = obj_dir
FLAGS     = --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINTFLAGS = --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
